// ==== core_top.f ====
hw/core_pkg.sv
hw/mem_port_if.sv
hw/fetch_stage.sv
hw/decode_regread.sv
hw/execute_stage.sv
hw/hazard_unit.sv
hw/mem_arbiter.sv
hw/unified_mem.sv
hw/core_top.sv
dv/tb_core_top.sv

// ==== Bender.yml ====
package:
  name: core_top

sources:
  - hw/core_pkg.sv
  - hw/mem_port_if.sv
  - hw/fetch_stage.sv
  - hw/decode_regread.sv
  - hw/execute_stage.sv
  - hw/hazard_unit.sv
  - hw/mem_arbiter.sv
  - hw/unified_mem.sv
  - hw/core_top.sv
  - target: simulation
    files:
      - dv/tb_core_top.sv

// ==== dv/tb_core_top.sv ====
// Random-program testbench that checks the core's retire stream against an instruction-set model
`timescale 1ns/100ps

module tb_core_top;
    import core_pkg::*;

    localparam int    MEM_WORDS      = 1024;
    localparam addr_t ADDR_MASK      = addr_t'(MEM_WORDS * 4 - 1);
    localparam addr_t DATA_BASE      = 32'h0000_0800;
    localparam int    DATA_WORDS     = 16;
    localparam int    BODY_END       = 48;
    localparam int    PROG_MAX       = 64;
    localparam int    RETIRE_TIMEOUT = 400;

    logic      clk;
    logic      rst_n;
    logic      load_we;
    addr_t     load_addr;
    word_t     load_data;
    logic      retire_valid;
    addr_t     retire_pc;
    reg_addr_t retire_rd;
    word_t     retire_value;

    logic [15:0] lfsr = 16'd56;
    word_t       prog [PROG_MAX];
    int          prog_len;
    word_t       data_model [DATA_WORDS];

    // Expected retire stream, one entry per instruction in program order
    addr_t       exp_pc [$];
    reg_addr_t   exp_rd [$];
    word_t       exp_value [$];
    logic        exp_has_value [$];

    core_top #(
        .MEM_WORDS (MEM_WORDS)
    ) uut (
        .clk_i          (clk         ),
        .rst_n_i        (rst_n       ),
        .load_we_i      (load_we     ),
        .load_addr_i    (load_addr   ),
        .load_data_i    (load_data   ),
        .retire_valid_o (retire_valid),
        .retire_pc_o    (retire_pc   ),
        .retire_rd_o    (retire_rd   ),
        .retire_value_o (retire_value)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1;
    end

    // 16-bit Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic word_t fill_word(input addr_t a);
        return {a[15:0], ~a[15:0]} ^ {a[31:16], a[31:16]};
    endfunction

    // Ops 0 to 5 are ADD, SUB, AND, OR, XOR and SLT
    function automatic word_t enc_r(input int op, input reg_addr_t rd, input reg_addr_t rs1,
                                    input reg_addr_t rs2);
        logic [2:0] f3;
        case (op)
            2:       f3 = 3'b111;
            3:       f3 = 3'b110;
            4:       f3 = 3'b100;
            5:       f3 = 3'b010;
            default: f3 = 3'b000;
        endcase
        return {(op == 1) ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                    input reg_addr_t rd, input logic [6:0] opc);
        return {imm, rs1, 3'b010 & {3{opc == OPC_LOAD}}, rd, opc};  // LW or ADDI
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input reg_addr_t rs2);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic word_t enc_b(input logic [2:0] f3, input reg_addr_t rs1,
                                    input reg_addr_t rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic word_t enc_j(input reg_addr_t rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    task automatic build_program();
        int          n;
        int          r;
        int          sel;
        int          skip;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic [11:0] off;
        n = 0;
        for (r = 1; r < 8; r++) begin
            prog[n] = enc_i(12'(rand_bits(12)), 5'd0, reg_addr_t'(r), OPC_OPIMM);
            n++;
        end
        while (n < BODY_END) begin
            sel  = int'(rand_bits(4));
            rd   = reg_addr_t'(rand_bits(3));
            rs1  = reg_addr_t'(rand_bits(3));
            rs2  = reg_addr_t'(rand_bits(3));
            off  = 12'h800 | 12'(rand_bits(4) << 2);  // x0 minus 2 KB wraps onto the data region
            skip = 1 + int'(rand_bits(2));
            if (n + skip > BODY_END) begin
                skip = BODY_END - n;  // Forward targets stay inside the program
            end
            case (sel)
                5, 6: prog[n] = enc_i(12'(rand_bits(12)), rs1, rd, OPC_OPIMM);
                7:    prog[n] = {20'(rand_bits(20)), rd, OPC_LUI};
                8:    prog[n] = enc_i(off, 5'd0, rd, OPC_LOAD);
                9: begin
                    prog[n] = enc_i(off, 5'd0, rd, OPC_LOAD);
                    n++;
                    prog[n] = enc_r(0, rs1, rd, rs2);  // Load-use pair
                end
                10:   prog[n] = enc_s(off, rs2);
                11: begin
                    prog[n] = enc_s(off, rs2);
                    n++;
                    prog[n] = enc_i(off, 5'd0, rd, OPC_LOAD);
                end
                12, 13: begin
                    if (rand_bits(1) == 1) begin
                        rs2 = rs1;
                    end
                    prog[n] = enc_b((sel == 12) ? 3'b000 : 3'b001, rs1, rs2, 13'(skip * 4));
                end
                14:      prog[n] = enc_j(rd, 21'(skip * 4));
                default: prog[n] = enc_r(int'(rand_bits(3)) % 6, rd, rs1, rs2);
            endcase
            n++;
        end
        prog[n] = enc_j(5'd0, 21'd0);  // Halt
        for (r = 1; r <= 4; r++) begin
            prog[n + r] = 32'h0000_0013;  // Prefetch past the halt lands on NOPs
        end
        prog_len = n + 5;
    endtask

    task automatic run_model();
        word_t     x [32];
        addr_t     pc;
        addr_t     next_pc;
        addr_t     ea;
        word_t     ins;
        word_t     a;
        word_t     b;
        word_t     val;
        reg_addr_t rd;
        logic      has_val;
        logic      halted;
        int        i;
        for (i = 0; i < 32; i++) begin
            x[i] = '0;
        end
        for (i = 0; i < DATA_WORDS; i++) begin
            data_model[i] = fill_word(DATA_BASE + addr_t'(4 * i));
        end
        pc     = '0;
        halted = 1'b0;
        i      = 0;
        while (!halted && i < PROG_MAX) begin
            ins     = prog[pc >> 2];
            a       = x[ins[19:15]];
            b       = x[ins[24:20]];
            rd      = ins[11:7];
            next_pc = pc + 32'd4;
            has_val = 1'b1;
            val     = '0;
            case (ins[6:0])
                OPC_OP: begin
                    case (ins[14:12])
                        3'b000:  val = ins[30] ? a - b : a + b;
                        3'b010:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        3'b100:  val = a ^ b;
                        3'b110:  val = a | b;
                        default: val = a & b;
                    endcase
                end
                OPC_OPIMM: val = a + {{20{ins[31]}}, ins[31:20]};
                OPC_LUI:   val = {ins[31:12], 12'b0};
                OPC_LOAD: begin
                    ea  = (a + {{20{ins[31]}}, ins[31:20]}) & ADDR_MASK;
                    val = data_model[(ea - DATA_BASE) >> 2];
                end
                OPC_STORE: begin
                    ea = (a + {{20{ins[31]}}, ins[31:25], ins[11:7]}) & ADDR_MASK;
                    data_model[(ea - DATA_BASE) >> 2] = b;
                    val = b;
                    rd  = '0;
                end
                OPC_BRANCH: begin
                    has_val = 1'b0;
                    rd      = '0;
                    if ((ins[14:12] == 3'b000) ? (a == b) : (a != b)) begin
                        next_pc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                        ins[11:8], 1'b0};
                    end
                end
                OPC_JAL: begin
                    val     = pc + 32'd4;
                    next_pc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20],
                                    ins[30:21], 1'b0};
                    halted  = (next_pc == pc);
                end
                default: begin
                    has_val = 1'b0;
                    rd      = '0;
                end
            endcase
            if (rd != '0) begin
                x[rd] = val;
            end
            exp_pc.push_back(pc);
            exp_rd.push_back(rd);
            exp_value.push_back(val);
            exp_has_value.push_back(has_val);
            pc = next_pc;
            i++;
        end
    endtask

    task automatic write_word(input addr_t a, input word_t d);
        @(posedge clk);
        #1;
        load_we   = 1'b1;
        load_addr = a;
        load_data = d;
    endtask

    // The loader outranks fetch, so words written after reset still land before the first fetch
    task automatic load_memory();
        int i;
        for (i = 0; i < prog_len; i++) begin
            write_word(addr_t'(4 * i), prog[i]);
        end
        for (i = 0; i < DATA_WORDS; i++) begin
            write_word(DATA_BASE + addr_t'(4 * i), fill_word(DATA_BASE + addr_t'(4 * i)));
        end
        @(posedge clk);
        #1;
        load_we = 1'b0;
    endtask

    task automatic report_mismatch(input string msg);
        $display("FAIL %0d ns: %s", $time, msg);
        $display("FAIL: see errors above");
        $fatal(1, "Retire stream mismatch");
    endtask

    task automatic wait_retire(input int n);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!retire_valid && cycles < RETIRE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!retire_valid) begin
            $display("Timeout: retirement %0d at pc %08h never arrived", n, exp_pc[n]);
            $display("FAIL: see errors above");
            $fatal(1, "Retirement timeout");
        end
    endtask

    task automatic check_retire(input int n);
        assert (retire_pc == exp_pc[n]) else
            report_mismatch($sformatf("retirement %0d pc %08h, expected %08h",
                                      n, retire_pc, exp_pc[n]));
        assert (retire_rd == exp_rd[n]) else
            report_mismatch($sformatf("retirement %0d at pc %08h rd %0d, expected %0d",
                                      n, retire_pc, retire_rd, exp_rd[n]));
        assert (!exp_has_value[n] || retire_value == exp_value[n]) else
            report_mismatch($sformatf("retirement %0d at pc %08h value %08h, expected %08h",
                                      n, retire_pc, retire_value, exp_value[n]));
    endtask

    initial begin
        int n;
        load_we   = 1'b0;
        load_addr = '0;
        load_data = '0;
        build_program();
        run_model();
        load_memory();
        for (n = 0; n < exp_pc.size(); n++) begin
            wait_retire(n);
            check_retire(n);  // Sampled mid-cycle, in order only
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== hw/core_top.sv ====
// Top level of the core subsystem: pipeline stages, hazard unit, arbiter and shared memory
`timescale 1ns/100ps

module core_top #(
    parameter int MEM_WORDS = 1024
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                load_we_i,
    input  core_pkg::addr_t     load_addr_i,
    input  core_pkg::word_t     load_data_i,
    output logic                retire_valid_o,
    output core_pkg::addr_t     retire_pc_o,
    output core_pkg::reg_addr_t retire_rd_o,
    output core_pkg::word_t     retire_value_o
);
    import core_pkg::*;

    mem_port_if imem_if ();
    mem_port_if dmem_if ();

    word_t     f_instr_w;
    addr_t     f_pc_w;
    logic      f_valid_w;

    reg_addr_t d_rs1_w;
    reg_addr_t d_rs2_w;
    uop_e      d_uop_w;
    word_t     d_op1_w;
    word_t     d_op2_w;
    word_t     d_imm_w;
    reg_addr_t d_rd_w;
    addr_t     d_pc_w;
    logic      d_valid_w;

    word_t     ex_result_w;
    logic      wb_we_w;
    reg_addr_t wb_rd_w;
    word_t     wb_value_w;
    logic      load_pending_w;
    logic      busy_w;
    logic      redirect_w;
    addr_t     target_w;

    fwd_sel_e  fwd1_w;
    fwd_sel_e  fwd2_w;
    logic      stall_w;
    logic      flush_w;

    logic      mem_en_w;
    logic      mem_we_w;
    addr_t     mem_addr_w;
    word_t     mem_wdata_w;
    word_t     mem_rdata_w;

    fetch_stage fetch_stage_dut (
        .clk_i    (clk_i    ),
        .rst_n_i  (rst_n_i  ),
        .imem     (imem_if  ),
        .stall_i  (stall_w  ),
        .flush_i  (flush_w  ),
        .target_i (target_w ),
        .instr_o  (f_instr_w),
        .pc_o     (f_pc_w   ),
        .valid_o  (f_valid_w)
    );

    decode_regread decode_regread_dut (
        .clk_i       (clk_i      ),
        .rst_n_i     (rst_n_i    ),
        .instr_i     (f_instr_w  ),
        .pc_i        (f_pc_w     ),
        .valid_i     (f_valid_w  ),
        .stall_i     (stall_w    ),
        .flush_i     (flush_w    ),
        .fwd1_i      (fwd1_w     ),
        .fwd2_i      (fwd2_w     ),
        .ex_result_i (ex_result_w),
        .wb_we_i     (wb_we_w    ),
        .wb_rd_i     (wb_rd_w    ),
        .wb_value_i  (wb_value_w ),
        .rs1_o       (d_rs1_w    ),
        .rs2_o       (d_rs2_w    ),
        .uop_o       (d_uop_w    ),
        .op1_o       (d_op1_w    ),
        .op2_o       (d_op2_w    ),
        .imm_o       (d_imm_w    ),
        .rd_o        (d_rd_w     ),
        .pc_o        (d_pc_w     ),
        .valid_o     (d_valid_w  )
    );

    execute_stage execute_stage_dut (
        .clk_i          (clk_i         ),
        .rst_n_i        (rst_n_i       ),
        .dmem           (dmem_if       ),
        .uop_i          (d_uop_w       ),
        .op1_i          (d_op1_w       ),
        .op2_i          (d_op2_w       ),
        .imm_i          (d_imm_w       ),
        .rd_i           (d_rd_w        ),
        .pc_i           (d_pc_w        ),
        .valid_i        (d_valid_w     ),
        .result_o       (ex_result_w   ),
        .wb_we_o        (wb_we_w       ),
        .wb_rd_o        (wb_rd_w       ),
        .wb_value_o     (wb_value_w    ),
        .load_pending_o (load_pending_w),
        .busy_o         (busy_w        ),
        .redirect_o     (redirect_w    ),
        .target_o       (target_w      ),
        .retire_valid_o (retire_valid_o),
        .retire_pc_o    (retire_pc_o   ),
        .retire_rd_o    (retire_rd_o   ),
        .retire_value_o (retire_value_o)
    );

    hazard_unit hazard_unit_dut (
        .rs1_i          (d_rs1_w       ),
        .rs2_i          (d_rs2_w       ),
        .ex_rd_i        (wb_rd_w       ),
        .ex_we_i        (wb_we_w       ),
        .load_pending_i (load_pending_w),
        .busy_i         (busy_w        ),
        .redirect_i     (redirect_w    ),
        .fwd1_o         (fwd1_w        ),
        .fwd2_o         (fwd2_w        ),
        .stall_o        (stall_w       ),
        .flush_o        (flush_w       )
    );

    mem_arbiter #(
        .MEM_WORDS (MEM_WORDS)
    ) mem_arbiter_dut (
        .clk_i       (clk_i      ),
        .rst_n_i     (rst_n_i    ),
        .load_we_i   (load_we_i  ),
        .load_addr_i (load_addr_i),
        .load_data_i (load_data_i),
        .fetch       (imem_if    ),
        .data        (dmem_if    ),
        .mem_en_o    (mem_en_w   ),
        .mem_we_o    (mem_we_w   ),
        .mem_addr_o  (mem_addr_w ),
        .mem_wdata_o (mem_wdata_w),
        .mem_rdata_i (mem_rdata_w)
    );

    unified_mem #(
        .MEM_WORDS (MEM_WORDS)
    ) unified_mem_dut (
        .clk_i   (clk_i      ),
        .en_i    (mem_en_w   ),
        .we_i    (mem_we_w   ),
        .addr_i  (mem_addr_w ),
        .wdata_i (mem_wdata_w),
        .rdata_o (mem_rdata_w)
    );

endmodule

// ==== hw/unified_mem.sv ====
// Single-port synchronous word memory that holds both the program and its data
`timescale 1ns/100ps

module unified_mem #(
    parameter int MEM_WORDS = 1024
) (
    input  logic            clk_i,
    input  logic            en_i,
    input  logic            we_i,
    input  core_pkg::addr_t addr_i,
    input  core_pkg::word_t wdata_i,
    output core_pkg::word_t rdata_o
);
    import core_pkg::*;

    localparam int IDX_W = $clog2(MEM_WORDS);

    word_t             mem [MEM_WORDS];
    logic [IDX_W-1:0]  idx;

    assign idx = addr_i[IDX_W+1:2];  // Word addressed, byte offset ignored

    always_ff @(posedge clk_i) begin
        if (en_i) begin
            if (we_i) begin
                mem[idx] <= wdata_i;
            end else begin
                rdata_o <= mem[idx];
            end
        end
    end

endmodule

// ==== hw/mem_arbiter.sv ====
// Fixed-priority arbiter that shares the single memory port between loader, data and fetch
`timescale 1ns/100ps

module mem_arbiter #(
    parameter int MEM_WORDS = 1024
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            load_we_i,
    input  core_pkg::addr_t load_addr_i,
    input  core_pkg::word_t load_data_i,
    mem_port_if.arbiter     fetch,
    mem_port_if.arbiter     data,
    output logic            mem_en_o,
    output logic            mem_we_o,
    output core_pkg::addr_t mem_addr_o,
    output core_pkg::word_t mem_wdata_o,
    input  core_pkg::word_t mem_rdata_i
);
    import core_pkg::*;

    localparam addr_t ADDR_MASK = addr_t'(MEM_WORDS * 4 - 1);

    logic  data_rd_q;   // Next cycle's read data belongs to the data port
    logic  fetch_rd_q;
    addr_t sel_addr;

    // Loader first, then data, then fetch
    assign data.mem_wait  = data.req && load_we_i;
    assign fetch.mem_wait = fetch.req && (load_we_i || data.req);

    always_comb begin
        mem_en_o = 1'b1;
        if (load_we_i) begin
            mem_we_o    = 1'b1;
            sel_addr    = load_addr_i;
            mem_wdata_o = load_data_i;
        end else if (data.req) begin
            mem_we_o    = data.we;
            sel_addr    = data.addr;
            mem_wdata_o = data.wdata;
        end else begin
            mem_en_o    = fetch.req;
            mem_we_o    = fetch.we;
            sel_addr    = fetch.addr;
            mem_wdata_o = fetch.wdata;
        end
    end

    assign mem_addr_o = sel_addr & ADDR_MASK;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            data_rd_q  <= 1'b0;
            fetch_rd_q <= 1'b0;
        end else begin
            data_rd_q  <= !load_we_i && data.req && !data.we;
            fetch_rd_q <= !load_we_i && !data.req && fetch.req && !fetch.we;
        end
    end

    assign data.rdata  = data_rd_q ? mem_rdata_i : '0;
    assign fetch.rdata = fetch_rd_q ? mem_rdata_i : '0;

endmodule

// ==== hw/hazard_unit.sv ====
// Hazard unit: forward selects for decode, load-use and busy stalls, and flushes on a redirect
`timescale 1ns/100ps

module hazard_unit (
    input  core_pkg::reg_addr_t rs1_i,
    input  core_pkg::reg_addr_t rs2_i,
    input  core_pkg::reg_addr_t ex_rd_i,
    input  logic                ex_we_i,
    input  logic                load_pending_i,
    input  logic                busy_i,
    input  logic                redirect_i,
    output core_pkg::fwd_sel_e  fwd1_o,
    output core_pkg::fwd_sel_e  fwd2_o,
    output logic                stall_o,
    output logic                flush_o
);
    import core_pkg::*;

    logic hit1;
    logic hit2;
    logic load_use;

    assign hit1 = (ex_rd_i != '0) && (ex_rd_i == rs1_i);
    assign hit2 = (ex_rd_i != '0) && (ex_rd_i == rs2_i);

    assign fwd1_o = (ex_we_i && hit1) ? FWD_EX : FWD_RF;
    assign fwd2_o = (ex_we_i && hit2) ? FWD_EX : FWD_RF;

    assign load_use = load_pending_i && (hit1 || hit2);  // Load data is not back yet

    assign stall_o = load_use || busy_i;
    assign flush_o = redirect_i;

endmodule

// ==== hw/execute_stage.sv ====
// Execute stage: ALU, branch resolution, load and store on the data port, writeback and retirement
`timescale 1ns/100ps

module execute_stage (
    input  logic                clk_i,
    input  logic                rst_n_i,
    mem_port_if.requester       dmem,
    input  core_pkg::uop_e      uop_i,
    input  core_pkg::word_t     op1_i,
    input  core_pkg::word_t     op2_i,
    input  core_pkg::word_t     imm_i,
    input  core_pkg::reg_addr_t rd_i,
    input  core_pkg::addr_t     pc_i,
    input  logic                valid_i,
    output core_pkg::word_t     result_o,
    output logic                wb_we_o,
    output core_pkg::reg_addr_t wb_rd_o,
    output core_pkg::word_t     wb_value_o,
    output logic                load_pending_o,
    output logic                busy_o,
    output logic                redirect_o,
    output core_pkg::addr_t     target_o,
    output logic                retire_valid_o,
    output core_pkg::addr_t     retire_pc_o,
    output core_pkg::reg_addr_t retire_rd_o,
    output core_pkg::word_t     retire_value_o
);
    import core_pkg::*;

    logic  is_mem;
    logic  is_store;
    logic  phase_q;  // Load read granted, its data arrives this cycle
    logic  done;
    logic  taken;
    word_t result;

    assign is_store = (uop_i == UOP_STORE);
    assign is_mem   = is_store || (uop_i == UOP_LOAD);

    assign dmem.req   = valid_i && is_mem && !phase_q;
    assign dmem.we    = is_store;
    assign dmem.addr  = op1_i + imm_i;
    assign dmem.wdata = op2_i;

    always_comb begin
        case (uop_i)
            UOP_SUB:  result = op1_i - op2_i;
            UOP_AND:  result = op1_i & op2_i;
            UOP_OR:   result = op1_i | op2_i;
            UOP_XOR:  result = op1_i ^ op2_i;
            UOP_SLT:  result = {31'b0, $signed(op1_i) < $signed(op2_i)};
            UOP_LUI:  result = imm_i;
            UOP_LOAD: result = dmem.rdata;
            UOP_JAL:  result = pc_i + 32'd4;
            default:  result = op1_i + op2_i;
        endcase
    end

    // A store completes when granted, a load one cycle after its grant
    assign done  = valid_i && (!is_mem || phase_q || (is_store && !dmem.mem_wait));
    assign taken = (uop_i == UOP_JAL) ||
                   (uop_i == UOP_BEQ && op1_i == op2_i) ||
                   (uop_i == UOP_BNE && op1_i != op2_i);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || phase_q) begin
            phase_q <= 1'b0;
        end else if (dmem.req && !is_store && !dmem.mem_wait) begin
            phase_q <= 1'b1;
        end
    end

    assign result_o       = result;
    assign wb_we_o        = done && rd_i != '0;
    assign wb_rd_o        = rd_i;
    assign wb_value_o     = result;
    assign load_pending_o = valid_i && uop_i == UOP_LOAD && !phase_q;
    assign busy_o         = valid_i && !done;
    assign redirect_o     = done && taken;
    assign target_o       = pc_i + imm_i;

    assign retire_valid_o = done;
    assign retire_pc_o    = pc_i;
    assign retire_rd_o    = rd_i;
    assign retire_value_o = is_store ? op2_i : result;

endmodule

// ==== hw/decode_regread.sv ====
// Decode and register-read stage: decodes into a micro-op, reads and forwards operands for execute
`timescale 1ns/100ps

module decode_regread (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  core_pkg::word_t     instr_i,
    input  core_pkg::addr_t     pc_i,
    input  logic                valid_i,
    input  logic                stall_i,
    input  logic                flush_i,
    input  core_pkg::fwd_sel_e  fwd1_i,
    input  core_pkg::fwd_sel_e  fwd2_i,
    input  core_pkg::word_t     ex_result_i,
    input  logic                wb_we_i,
    input  core_pkg::reg_addr_t wb_rd_i,
    input  core_pkg::word_t     wb_value_i,
    output core_pkg::reg_addr_t rs1_o,
    output core_pkg::reg_addr_t rs2_o,
    output core_pkg::uop_e      uop_o,
    output core_pkg::word_t     op1_o,
    output core_pkg::word_t     op2_o,
    output core_pkg::word_t     imm_o,
    output core_pkg::reg_addr_t rd_o,
    output core_pkg::addr_t     pc_o,
    output logic                valid_o
);
    import core_pkg::*;

    word_t      regs [32];
    logic [6:0] opcode;
    logic [2:0] funct3;
    uop_e       uop;
    word_t      imm;
    reg_addr_t  rd;
    logic       use_imm;
    word_t      rs1_val;
    word_t      rs2_val;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign rs1_o  = instr_i[19:15];
    assign rs2_o  = instr_i[24:20];

    always_comb begin
        uop     = UOP_NOP;
        imm     = '0;
        use_imm = 1'b0;
        case (opcode)
            OPC_OP: begin
                case (funct3)
                    3'b000:  uop = instr_i[30] ? UOP_SUB : UOP_ADD;
                    3'b010:  uop = UOP_SLT;
                    3'b100:  uop = UOP_XOR;
                    3'b110:  uop = UOP_OR;
                    3'b111:  uop = UOP_AND;
                    default: uop = UOP_NOP;
                endcase
            end
            OPC_OPIMM: begin
                imm     = {{20{instr_i[31]}}, instr_i[31:20]};
                use_imm = 1'b1;
                uop     = (funct3 == 3'b000) ? UOP_ADD : UOP_NOP;  // Only ADDI
            end
            OPC_LUI: begin
                imm = {instr_i[31:12], 12'b0};
                uop = UOP_LUI;
            end
            OPC_LOAD: begin
                imm = {{20{instr_i[31]}}, instr_i[31:20]};
                uop = (funct3 == 3'b010) ? UOP_LOAD : UOP_NOP;
            end
            OPC_STORE: begin
                imm = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
                uop = (funct3 == 3'b010) ? UOP_STORE : UOP_NOP;
            end
            OPC_BRANCH: begin
                imm = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                       instr_i[11:8], 1'b0};
                case (funct3)
                    3'b000:  uop = UOP_BEQ;
                    3'b001:  uop = UOP_BNE;
                    default: uop = UOP_NOP;
                endcase
            end
            OPC_JAL: begin
                imm = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                       instr_i[30:21], 1'b0};
                uop = UOP_JAL;
            end
            default: uop = UOP_NOP;
        endcase
        // Instructions without a destination retire with rd zero
        rd = (uop inside {UOP_STORE, UOP_BEQ, UOP_BNE, UOP_NOP}) ? '0 : instr_i[11:7];
    end

    assign rs1_val = (fwd1_i == FWD_EX) ? ex_result_i : (rs1_o == '0) ? '0 : regs[rs1_o];
    assign rs2_val = (fwd2_i == FWD_EX) ? ex_result_i : (rs2_o == '0) ? '0 : regs[rs2_o];

    always_ff @(posedge clk_i) begin
        if (wb_we_i && wb_rd_i != '0) begin
            regs[wb_rd_i] <= wb_value_i;
        end
    end

    // On a stall the registers hold, execute is still working on them
    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            uop_o <= uop;
            op1_o <= rs1_val;
            op2_o <= use_imm ? imm : rs2_val;
            imm_o <= imm;
            rd_o  <= rd;
            pc_o  <= pc_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            valid_o <= 1'b0;
        end else if (!stall_i) begin
            valid_o <= valid_i;
        end
    end

endmodule

// ==== hw/fetch_stage.sv ====
// Fetch stage: holds the PC, reads instructions through its memory port and buffers them for decode
`timescale 1ns/100ps

module fetch_stage (
    input  logic            clk_i,
    input  logic            rst_n_i,
    mem_port_if.requester   imem,
    input  logic            stall_i,
    input  logic            flush_i,
    input  core_pkg::addr_t target_i,
    output core_pkg::word_t instr_o,
    output core_pkg::addr_t pc_o,
    output logic            valid_o
);
    import core_pkg::*;

    addr_t pc_q;
    logic  run_q;
    logic  pend_q;       // A read was granted last cycle, its word is on rdata now
    addr_t pend_pc_q;
    logic  skid_v_q;
    word_t skid_instr_q;
    addr_t skid_pc_q;
    logic  take;
    logic  grant;

    // At most two words may be buffered or in flight, so a stall never drops one
    assign imem.req   = run_q && !skid_v_q && !(pend_q && valid_o) && !flush_i;
    assign imem.we    = 1'b0;
    assign imem.addr  = pc_q;
    assign imem.wdata = '0;

    assign grant = imem.req && !imem.mem_wait;
    assign take  = !valid_o || !stall_i;  // Output slot is empty or being consumed

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q     <= RESET_PC;
            run_q    <= 1'b0;
            pend_q   <= 1'b0;
            skid_v_q <= 1'b0;
            valid_o  <= 1'b0;
        end else if (flush_i) begin
            pc_q     <= target_i;  // The word in flight and both buffers are dropped
            pend_q   <= 1'b0;
            skid_v_q <= 1'b0;
            valid_o  <= 1'b0;
        end else begin
            run_q  <= 1'b1;
            pend_q <= grant;
            if (grant) begin
                pc_q      <= pc_q + 32'd4;
                pend_pc_q <= pc_q;
            end
            if (take) begin
                if (skid_v_q) begin
                    instr_o  <= skid_instr_q;
                    pc_o     <= skid_pc_q;
                    valid_o  <= 1'b1;
                    skid_v_q <= 1'b0;
                end else begin
                    instr_o <= imem.rdata;
                    pc_o    <= pend_pc_q;
                    valid_o <= pend_q;
                end
            end else if (pend_q) begin
                skid_instr_q <= imem.rdata; // Decode is stalled, park the returning word
                skid_pc_q    <= pend_pc_q;
                skid_v_q     <= 1'b1;
            end
        end
    end

endmodule

// ==== hw/mem_port_if.sv ====
// One memory requester port, owned by fetch or execute on one side and served by the arbiter
`timescale 1ns/100ps

interface mem_port_if;
    import core_pkg::*;

    logic  req;      // Held steady with its fields while mem_wait is high
    logic  we;
    addr_t addr;
    word_t wdata;
    word_t rdata;    // Valid the cycle after a granted read
    logic  mem_wait;

    modport requester (
        output req, we, addr, wdata,
        input  rdata, mem_wait
    );

    modport arbiter (
        input  req, we, addr, wdata,
        output rdata, mem_wait
    );

endinterface

// ==== hw/core_pkg.sv ====
// Shared types, opcode values and enums for the RV32I-subset core, imported by every RTL block
package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  reg_addr_t;

    localparam addr_t RESET_PC = 32'h0000_0000;

    // Major opcode field, instr[6:0]
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    typedef enum logic [3:0] {
        UOP_ADD,
        UOP_SUB,
        UOP_AND,
        UOP_OR,
        UOP_XOR,
        UOP_SLT,
        UOP_LUI,
        UOP_LOAD,
        UOP_STORE,
        UOP_BEQ,
        UOP_BNE,
        UOP_JAL,
        UOP_NOP
    } uop_e;

    typedef enum logic {
        FWD_RF, // Operand from the register file
        FWD_EX  // Operand from the instruction now in execute
    } fwd_sel_e;

endpackage
